// ==== logic/csr_pkg.sv ====
package csr_pkg;

  // ========================================
  // Widths and addresses
  // ========================================

  localparam int unsigned xlen = 32;  // RV32 data path

  typedef enum logic [11:0] {
    // Machine information, read only
    csr_mvendorid  = 12'hF11,
    csr_marchid    = 12'hF12,
    csr_mimpid     = 12'hF13,
    csr_mhartid    = 12'hF14,
    csr_mconfigptr = 12'hF15,
    // Trap setup
    csr_mstatus    = 12'h300,
    csr_misa       = 12'h301,
    csr_mie        = 12'h304,
    csr_mtvec      = 12'h305,
    csr_mstatush   = 12'h310,
    // Trap handling
    csr_mscratch   = 12'h340,
    csr_mepc       = 12'h341,
    csr_mcause     = 12'h342,
    csr_mtval      = 12'h343,
    csr_mip        = 12'h344,
    // Machine counters, low and high halves
    csr_mcycle     = 12'hB00,
    csr_minstret   = 12'hB02,
    csr_mcycleh    = 12'hB80,
    csr_minstreth  = 12'hB82,
    // User aliases of the counters
    csr_cycle      = 12'hC00,
    csr_instret    = 12'hC02,
    csr_cycleh     = 12'hC80,
    csr_instreth   = 12'hC82
  } csr_addr_e;

  // ========================================
  // Bit positions and masks
  // ========================================

  localparam int unsigned mstatus_mie_bit  = 3;
  localparam int unsigned mstatus_mpie_bit = 7;
  localparam int unsigned mstatus_mpp_hi   = 12;
  localparam int unsigned mstatus_mpp_lo   = 11;

  localparam int unsigned mip_msip_bit = 3;   // Software interrupt
  localparam int unsigned mip_mtip_bit = 7;   // Timer interrupt
  localparam int unsigned mip_meip_bit = 11;  // External interrupt

  localparam int unsigned misa_c_bit = 2;     // Compressed extension

  localparam logic [xlen-1:0] misa_reset   = 32'h4000_1104;  // RV32 I M C
  localparam logic [xlen-1:0] misa_wr_mask = 32'h0000_0004;  // Only C is WARL
  localparam logic [xlen-1:0] mie_wr_mask  = 32'h0000_0888;  // MSIE, MTIE, MEIE

  // ========================================
  // State structs
  // ========================================

  typedef struct packed {
    logic       mie;   // Global interrupt enable
    logic       mpie;  // MIE before the last trap
    logic [1:0] mpp;   // Previous privilege, machine only
  } mstatus_t;

  // Machine mode, interrupts off
  localparam mstatus_t mstatus_reset = '{mie: 1'b0, mpie: 1'b0, mpp: 2'b11};

  typedef struct packed {
    mstatus_t          mstatus;
    logic [xlen-1:0]   misa;
    logic [xlen-1:0]   mie;
    logic [xlen-1:0]   mtvec;
    logic [xlen-1:0]   mscratch;
    logic [xlen-1:0]   mepc;
    logic [xlen-1:0]   mcause;
    logic [xlen-1:0]   mtval;
  } trap_state_t;

  typedef struct packed {
    logic [2*xlen-1:0] mcycle;
    logic [2*xlen-1:0] minstret;
  } counter_state_t;

endpackage

// ==== logic/csr_wr_if.sv ====
interface csr_wr_if
  import csr_pkg::*;
();

  logic            wr_en;    // One cycle write strobe
  logic [11:0]     addr;     // Raw CSR address, may be unknown
  logic [xlen-1:0] wdata;
  logic            advance;  // Pipeline moves this cycle

  // Register blocks only listen
  modport reg_mp (
    input wr_en,
    input addr,
    input wdata,
    input advance
  );

endinterface

// ==== logic/csr_trap_regs.sv ====
module csr_trap_regs
  import csr_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  csr_wr_if.reg_mp        wr,

  input  logic            trap_i,        // Trap entry strobe
  input  logic            mret_i,        // Return from trap
  input  logic [xlen-1:0] trap_cause_i,
  input  logic [xlen-1:0] trap_epc_i,
  input  logic [xlen-1:0] trap_tval_i,
  input  logic [xlen-1:0] pc_i,          // Bit 1 guards the misa C write

  output trap_state_t     trap_state_o
);

  // ========================================
  // Register storage
  // ========================================

  mstatus_t        mstatus_q;
  logic [xlen-1:0] misa_q;
  logic [xlen-1:0] mie_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;

  logic misa_wr_refused;  // Clearing C with a half-word PC

  // Dropping C would leave the PC misaligned
  assign misa_wr_refused = !wr.wdata[misa_c_bit] && misa_q[misa_c_bit] && pc_i[1];

  // ========================================
  // Update, trap > mret > write
  // ========================================

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mstatus_q  <= mstatus_reset;
      misa_q     <= misa_reset;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else if (wr.advance) begin
      if (trap_i) begin
        // Trap entry
        mepc_q         <= trap_epc_i;
        mcause_q       <= trap_cause_i;
        mtval_q        <= trap_tval_i;
        mstatus_q.mpie <= mstatus_q.mie;  // Save enable
        mstatus_q.mie  <= 1'b0;           // Handler runs masked
        mstatus_q.mpp  <= 2'b11;
      end else if (mret_i) begin
        mstatus_q.mie  <= mstatus_q.mpie;  // Restore enable
        mstatus_q.mpie <= 1'b1;
        mstatus_q.mpp  <= 2'b11;           // Always back to machine mode
      end else if (wr.wr_en) begin
        case (wr.addr)
          csr_mstatus: begin
            // MPP is hardwired, only the two enables land
            mstatus_q.mie  <= wr.wdata[mstatus_mie_bit];
            mstatus_q.mpie <= wr.wdata[mstatus_mpie_bit];
            mstatus_q.mpp  <= 2'b11;
          end
          csr_misa: begin
            if (!misa_wr_refused) begin
              misa_q <= (misa_q & ~misa_wr_mask) | (wr.wdata & misa_wr_mask);
            end
          end
          csr_mie:      mie_q      <= (mie_q & ~mie_wr_mask) | (wr.wdata & mie_wr_mask);
          csr_mtvec:    mtvec_q    <= wr.wdata;
          csr_mscratch: mscratch_q <= wr.wdata;
          csr_mepc:     mepc_q     <= {wr.wdata[xlen-1:1], 1'b0};  // Never odd
          csr_mcause:   mcause_q   <= wr.wdata;
          csr_mtval:    mtval_q    <= wr.wdata;
          default: ;  // Counters and read-only space handled elsewhere
        endcase
      end
    end
  end

  // ========================================
  // State out to the read mux
  // ========================================

  always_comb begin
    trap_state_o.mstatus  = mstatus_q;
    trap_state_o.misa     = misa_q;
    trap_state_o.mie      = mie_q;
    trap_state_o.mtvec    = mtvec_q;
    trap_state_o.mscratch = mscratch_q;
    trap_state_o.mepc     = mepc_q;   // Raw, alignment applied on output
    trap_state_o.mcause   = mcause_q;
    trap_state_o.mtval    = mtval_q;
  end

endmodule

// ==== logic/csr_counters.sv ====
module csr_counters
  import csr_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  csr_wr_if.reg_mp       wr,
  input  logic           trap_i,           // A trapped instruction does not retire
  output counter_state_t counter_state_o
);

  logic [2*xlen-1:0] mcycle_q, mcycle_d;
  logic [2*xlen-1:0] minstret_q, minstret_d;

  logic wr_cyc_lo, wr_cyc_hi;  // Software writes per half
  logic wr_ret_lo, wr_ret_hi;
  logic ret_inc;

  // Increment with carry across halves, then let writes replace a half
  function automatic logic [2*xlen-1:0] count_next(
    input logic [2*xlen-1:0] cur,
    input logic              inc,
    input logic              wr_lo,
    input logic              wr_hi,
    input logic [xlen-1:0]   wdata
  );
    logic [2*xlen-1:0] nxt;
    nxt = inc ? cur + 1'b1 : cur;
    if (wr_lo) nxt[xlen-1:0]      = wdata;
    if (wr_hi) nxt[2*xlen-1:xlen] = wdata;
    return nxt;
  endfunction

  assign wr_cyc_lo = wr.wr_en && (wr.addr == csr_mcycle);
  assign wr_cyc_hi = wr.wr_en && (wr.addr == csr_mcycleh);
  assign wr_ret_lo = wr.wr_en && (wr.addr == csr_minstret);
  assign wr_ret_hi = wr.wr_en && (wr.addr == csr_minstreth);

  assign ret_inc = !trap_i && !wr_ret_lo && !wr_ret_hi;  // No retire on trap or own write

  assign mcycle_d   = count_next(mcycle_q, 1'b1, wr_cyc_lo, wr_cyc_hi, wr.wdata);
  assign minstret_d = count_next(minstret_q, ret_inc, wr_ret_lo, wr_ret_hi, wr.wdata);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else if (wr.advance) begin  // Frozen while stalled
      mcycle_q   <= mcycle_d;
      minstret_q <= minstret_d;
    end
  end

  assign counter_state_o.mcycle   = mcycle_q;
  assign counter_state_o.minstret = minstret_q;

endmodule

// ==== logic/csr_read_mux.sv ====
module csr_read_mux
  import csr_pkg::*;
#(
  parameter logic [xlen-1:0] HART_ID = 32'd0,
  parameter logic [xlen-1:0] ARCH_ID = 32'd5
) (
  input  logic            rd_en_i,
  input  logic [11:0]     addr_i,
  input  trap_state_t     trap_state_i,
  input  counter_state_t  counter_state_i,
  input  logic            sw_irq_i,     // MSIP source
  input  logic            timer_irq_i,  // MTIP source
  input  logic            ext_irq_i,    // MEIP source
  output logic [xlen-1:0] rdata_o,
  output logic [xlen-1:0] mtvec_o,
  output logic [xlen-1:0] mepc_o,
  output logic            misa_c_o
);

  logic [xlen-1:0] mstatus_rd;
  logic [xlen-1:0] mip_rd;

  // ========================================
  // Packed views
  // ========================================

  always_comb begin
    mstatus_rd                                  = '0;
    mstatus_rd[mstatus_mie_bit]                 = trap_state_i.mstatus.mie;
    mstatus_rd[mstatus_mpie_bit]                = trap_state_i.mstatus.mpie;
    mstatus_rd[mstatus_mpp_hi:mstatus_mpp_lo]   = trap_state_i.mstatus.mpp;

    // Pending bits straight from the lines, not writable
    mip_rd               = '0;
    mip_rd[mip_msip_bit] = sw_irq_i;
    mip_rd[mip_mtip_bit] = timer_irq_i;
    mip_rd[mip_meip_bit] = ext_irq_i;
  end

  // ========================================
  // Read decode
  // ========================================

  always_comb begin
    rdata_o = '0;  // Disabled read or unknown address
    if (rd_en_i) begin
      case (addr_i)
        csr_mhartid:               rdata_o = HART_ID;
        csr_marchid:               rdata_o = ARCH_ID;
        csr_mstatus:               rdata_o = mstatus_rd;
        csr_misa:                  rdata_o = trap_state_i.misa;
        csr_mie:                   rdata_o = trap_state_i.mie;
        csr_mtvec:                 rdata_o = trap_state_i.mtvec;
        csr_mscratch:              rdata_o = trap_state_i.mscratch;
        csr_mepc:                  rdata_o = trap_state_i.mepc;
        csr_mcause:                rdata_o = trap_state_i.mcause;
        csr_mtval:                 rdata_o = trap_state_i.mtval;
        csr_mip:                   rdata_o = mip_rd;
        csr_mcycle,   csr_cycle:   rdata_o = counter_state_i.mcycle[xlen-1:0];
        csr_mcycleh,  csr_cycleh:  rdata_o = counter_state_i.mcycle[2*xlen-1:xlen];
        csr_minstret, csr_instret: rdata_o = counter_state_i.minstret[xlen-1:0];
        csr_minstreth, csr_instreth: begin
          rdata_o = counter_state_i.minstret[2*xlen-1:xlen];
        end
        // mvendorid, mimpid, mconfigptr and mstatush all read zero
        default: rdata_o = '0;
      endcase
    end
  end

  assign misa_c_o = trap_state_i.misa[misa_c_bit];
  assign mtvec_o  = trap_state_i.mtvec;
  // Half-word aligned with C, word aligned without
  assign mepc_o   = misa_c_o ? {trap_state_i.mepc[xlen-1:1], 1'b0}
                             : {trap_state_i.mepc[xlen-1:2], 2'b00};

endmodule

// ==== logic/csr_file.sv ====
module csr_file
  import csr_pkg::*;
#(
  parameter logic [xlen-1:0] HART_ID = 32'd0,
  parameter logic [xlen-1:0] ARCH_ID = 32'd5
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            stall_i,       // Pipeline held this cycle

  // CSR access from the execute stage
  input  logic            rd_en_i,
  input  logic            wr_en_i,
  input  logic [11:0]     csr_addr_i,
  input  logic [xlen-1:0] csr_wdata_i,
  output logic [xlen-1:0] csr_rdata_o,

  // Trap and return
  input  logic            trap_i,
  input  logic            mret_i,
  input  logic [xlen-1:0] trap_cause_i,
  input  logic [xlen-1:0] trap_epc_i,
  input  logic [xlen-1:0] trap_tval_i,
  input  logic [xlen-1:0] pc_i,

  // Interrupt lines
  input  logic            sw_irq_i,
  input  logic            timer_irq_i,
  input  logic            ext_irq_i,

  output logic [xlen-1:0] mtvec_o,
  output logic [xlen-1:0] mepc_o,
  output logic            misa_c_o
);

  trap_state_t    trap_state;
  counter_state_t counter_state;

  csr_wr_if wr_if ();

  assign wr_if.wr_en   = wr_en_i;
  assign wr_if.addr    = csr_addr_i;
  assign wr_if.wdata   = csr_wdata_i;
  assign wr_if.advance = !stall_i || trap_i;  // A trap pushes through a stall

  csr_trap_regs u_trap_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr           (wr_if),
    .trap_i       (trap_i),
    .mret_i       (mret_i),
    .trap_cause_i (trap_cause_i),
    .trap_epc_i   (trap_epc_i),
    .trap_tval_i  (trap_tval_i),
    .pc_i         (pc_i),
    .trap_state_o (trap_state)
  );

  csr_counters u_counters (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wr              (wr_if),
    .trap_i          (trap_i),
    .counter_state_o (counter_state)
  );

  csr_read_mux #(
    .HART_ID (HART_ID),
    .ARCH_ID (ARCH_ID)
  ) u_read_mux (
    .rd_en_i         (rd_en_i),
    .addr_i          (csr_addr_i),
    .trap_state_i    (trap_state),
    .counter_state_i (counter_state),
    .sw_irq_i        (sw_irq_i),
    .timer_irq_i     (timer_irq_i),
    .ext_irq_i       (ext_irq_i),
    .rdata_o         (csr_rdata_o),
    .mtvec_o         (mtvec_o),
    .mepc_o          (mepc_o),
    .misa_c_o        (misa_c_o)
  );

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);  // Held for 10 cycles
    #1 rst_no = 1'b1;
  end
endmodule

// ==== dv/csr_file_tb.sv ====
module csr_file_tb
  import csr_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned max_cycles   = 2000;  // Tests use under 150
  localparam int unsigned sample_delay = 8;     // 1 ns before the next edge

  logic        clk, rst_n;
  logic        stall, rd_en, wr_en;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata, csr_rdata;
  logic        trap, mret;
  logic [31:0] trap_cause, trap_epc, trap_tval, pc;
  logic        sw_irq, timer_irq, ext_irq;
  logic [31:0] mtvec, mepc;
  logic        misa_c;

  int unsigned cycle_count = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_start_errors = 0;

  tb_clock u_clock (.clk_o(clk), .rst_no(rst_n));

  csr_file #(
    .HART_ID (32'd0),
    .ARCH_ID (32'd5)
  ) csr_file_i (
    .clk_i (clk), .rst_ni (rst_n), .stall_i (stall),
    .rd_en_i (rd_en), .wr_en_i (wr_en), .csr_addr_i (csr_addr),
    .csr_wdata_i (csr_wdata), .csr_rdata_o (csr_rdata),
    .trap_i (trap), .mret_i (mret), .trap_cause_i (trap_cause),
    .trap_epc_i (trap_epc), .trap_tval_i (trap_tval), .pc_i (pc),
    .sw_irq_i (sw_irq), .timer_irq_i (timer_irq), .ext_irq_i (ext_irq),
    .mtvec_o (mtvec), .mepc_o (mepc), .misa_c_o (misa_c)
  );

  // ========================================
  // Concurrent checks
  // ========================================

  read_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !rd_en |-> csr_rdata == 32'h0)
    else begin
      $display("Error: read_idle expected %08h actual %08h", 32'h0, $sampled(csr_rdata));
      errors++;
    end

  // Without C the return address is word aligned
  mepc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    !misa_c |-> mepc[1:0] == 2'b00)
    else begin
      $display("Error: mepc_align expected %02b actual %02b", 2'b00, $sampled(mepc[1:0]));
      errors++;
    end

  always @(posedge clk) begin  // Hang guard
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: run passed %0d cycles without finishing", max_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ========================================
  // Stimulus helpers
  // ========================================

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive just after the edge
  endtask

  task automatic check_value(input string test, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp)
      else begin
        $display("Error: %s expected %08h actual %08h", test, exp, act);
        errors++;
      end
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    rd_en    = 1'b1;
    csr_addr = addr;
    #(sample_delay);
    data = csr_rdata;  // Combinational read, settled by now
    next_cycle();
    rd_en = 1'b0;
  endtask

  task automatic check_read(input string test, input logic [11:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    read_csr(addr, data);
    check_value(test, exp, data);
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    wr_en     = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    next_cycle();  // Lands on this edge if advancing
    wr_en = 1'b0;
  endtask

  task automatic finish_test(input string test);
    tests++;
    $display("Test %0d %s done, %0d errors", tests, test, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // ========================================
  // Directed tests
  // ========================================

  initial begin
    logic [31:0] rd_a;
    logic [31:0] rd_b;
    logic [31:0] scratch_val;
    logic [31:0] instret_val;
    int unsigned gap;
    void'($urandom(53));
    stall      = 1'b0;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    csr_addr   = '0;
    csr_wdata  = '0;
    trap       = 1'b0;
    mret       = 1'b0;
    trap_cause = '0;
    trap_epc   = '0;
    trap_tval  = '0;
    pc         = '0;
    sw_irq     = 1'b0;
    timer_irq  = 1'b0;
    ext_irq    = 1'b0;
    wait (rst_n === 1'b1);
    next_cycle();

    check_read("reset_state", csr_mstatus, 32'h0000_1800);  // MPP reads machine
    check_read("reset_state", csr_misa, 32'h4000_1104);     // RV32 I M C
    check_read("reset_state", csr_marchid, 32'd5);
    check_read("reset_state", csr_mhartid, 32'd0);
    check_read("reset_state", csr_mvendorid, 32'd0);
    check_read("reset_state", csr_mtvec, 32'd0);
    check_read("reset_state", 12'h7C0, 32'd0);  // Outside the map
    check_value("reset_state", 32'd1, {31'd0, misa_c});
    check_value("reset_state", 32'd0, mtvec);
    check_value("reset_state", 32'd0, mepc);
    finish_test("reset_state");

    write_csr(csr_mie, 32'hFFFF_FFFF);
    check_read("write_masks", csr_mie, 32'h0000_0888);  // MSIE MTIE MEIE only
    scratch_val = $urandom;
    write_csr(csr_mscratch, scratch_val);
    check_read("write_masks", csr_mscratch, scratch_val);
    write_csr(csr_mepc, 32'h0000_2001);
    check_read("write_masks", csr_mepc, 32'h0000_2000);  // Bit 0 dropped
    write_csr(csr_mtvec, 32'h0000_0100);
    check_value("write_masks", 32'h0000_0100, mtvec);
    sw_irq  = 1'b1;
    ext_irq = 1'b1;
    check_read("write_masks", csr_mip, 32'h0000_0808);
    sw_irq    = 1'b0;
    ext_irq   = 1'b0;
    timer_irq = 1'b1;
    check_read("write_masks", csr_mip, 32'h0000_0080);
    timer_irq = 1'b0;
    write_csr(csr_mip, 32'hFFFF_FFFF);  // Read only
    check_read("write_masks", csr_mip, 32'h0);
    stall = 1'b1;
    write_csr(csr_mscratch, ~scratch_val);  // Stalled, must not land
    check_read("write_masks", csr_mscratch, scratch_val);
    stall = 1'b0;
    finish_test("write_masks");

    write_csr(csr_mstatus, 32'h0000_0008);
    check_read("trap_mret", csr_mstatus, 32'h0000_1808);
    trap       = 1'b1;
    trap_cause = 32'h8000_0007;
    trap_epc   = 32'h0000_1236;
    trap_tval  = 32'hDEAD_BEEF;
    write_csr(csr_mscratch, ~scratch_val);  // Trap wins over the write
    trap = 1'b0;
    check_read("trap_mret", csr_mscratch, scratch_val);
    check_read("trap_mret", csr_mepc, 32'h0000_1236);
    check_read("trap_mret", csr_mcause, 32'h8000_0007);
    check_read("trap_mret", csr_mtval, 32'hDEAD_BEEF);
    check_read("trap_mret", csr_mstatus, 32'h0000_1880);  // MIE saved to MPIE
    mret = 1'b1;
    next_cycle();
    mret = 1'b0;
    check_read("trap_mret", csr_mstatus, 32'h0000_1888);
    finish_test("trap_mret");

    pc = 32'h0000_0002;  // Half-word PC blocks clearing C
    write_csr(csr_misa, 32'h0);
    check_read("misa_c", csr_misa, 32'h4000_1104);
    check_value("misa_c", 32'h0000_1236, mepc);
    pc = 32'h0000_0000;
    write_csr(csr_misa, 32'h0);
    check_read("misa_c", csr_misa, 32'h4000_1100);
    check_value("misa_c", 32'd0, {31'd0, misa_c});
    check_value("misa_c", 32'h0000_1234, mepc);  // Word aligned now
    write_csr(csr_misa, 32'h0000_0004);
    check_read("misa_c", csr_misa, 32'h4000_1104);
    check_value("misa_c", 32'd1, {31'd0, misa_c});
    finish_test("misa_c");

    gap = 2 + ($urandom % 8);
    read_csr(csr_mcycle, rd_a);
    repeat (gap - 1) next_cycle();
    read_csr(csr_mcycle, rd_b);
    check_value("counters", gap, rd_b - rd_a);
    instret_val = $urandom;
    write_csr(csr_minstret, instret_val);  // Own write, no retire count
    stall = 1'b1;  // Both counters frozen
    read_csr(csr_mcycle, rd_a);
    repeat (3) next_cycle();
    read_csr(csr_mcycle, rd_b);
    check_value("counters", rd_a, rd_b);
    check_read("counters", csr_minstret, instret_val);
    check_read("counters", csr_instret, instret_val);  // User alias
    stall = 1'b0;
    write_csr(csr_mcycleh, 32'h0);
    write_csr(csr_mcycle, 32'hFFFF_FFFF);
    next_cycle();  // Carry into the high half
    check_read("counters", csr_mcycleh, 32'd1);
    finish_test("counters");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end
endmodule

// ==== csr_file.f ====
logic/csr_pkg.sv
logic/csr_wr_if.sv
logic/csr_trap_regs.sv
logic/csr_counters.sv
logic/csr_read_mux.sv
logic/csr_file.sv
dv/tb_clock.sv
dv/csr_file_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then judge the run by its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module csr_file_tb -f csr_file.f -o csr_file_sim \
  && ./obj_dir/csr_file_sim | tee sim.log
grep -qx "TEST RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
